// ==== mem_pkg.sv ====
package mem_pkg;

    // access size, same code as data_sram_size
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_t;

    // one enable bit per byte lane
    typedef logic [3:0] strb_t;

    // base strobes before the lane shift
    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

endpackage

// ==== exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // operation class picks the view of the op word
    typedef enum logic [1:0] {
        CLS_ALU    = 2'd0,
        CLS_MULDIV = 2'd1,
        CLS_MEM    = 2'd2
    } op_class_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_fn_t;

    typedef struct packed {
        logic [3:0] pad;
        alu_fn_t    fn;
    } alu_op_s;

    // sel_hi: high product half, or remainder for a divide
    typedef struct packed {
        logic [4:0] pad;
        logic       is_div;
        logic       is_signed;
        logic       sel_hi;
    } md_op_s;

    typedef struct packed {
        logic [3:0]         pad;
        logic               is_store;
        mem_pkg::mem_size_t size;
        logic               ld_unsigned;
    } mem_op_s;

    typedef union packed {
        alu_op_s alu;
        md_op_s  md;
        mem_op_s mem;
    } ex_op_t;

endpackage

// ==== exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu
    import exe_pkg::*;
(
    input  alu_fn_t alu_fn,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       less_s;
    logic       less_u;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src2[4:0];

    // signed less-than from operand signs and the difference
    assign less_s = (src1[XLEN-1] & ~src2[XLEN-1])
                  | (~(src1[XLEN-1] ^ src2[XLEN-1]) & diff[XLEN-1]);
    assign less_u = src1 < src2;

    always_comb begin
        case (alu_fn)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, less_s};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, less_u};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;
            // immediate already shifted by decode
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

// ==== exe_muldiv.sv ====
`timescale 1ns/1ps

module exe_muldiv
    import exe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  md_op_s md_op,
    input  word_t  src1,
    input  word_t  src2,
    input  logic   start,
    output word_t  mul_result,
    output word_t  div_result,
    output logic   div_done
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [2*XLEN-1:0] mul_a;
    logic [2*XLEN-1:0] mul_b;
    logic [2*XLEN-1:0] product;

    logic             neg1;
    logic             neg2;
    word_t            mag1;
    word_t            mag2;
    word_t            quo;
    word_t            rem;
    word_t            dvsr;
    logic [CNT_W-1:0] cnt;
    logic             quo_neg;
    logic             rem_neg;
    logic             sel_rem;
    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    rem_diff;
    word_t            quo_fix;
    word_t            rem_fix;

    // sign-extend to 64 bits, low 64 of the product are exact either way
    assign mul_a   = {{XLEN{md_op.is_signed & src1[XLEN-1]}}, src1};
    assign mul_b   = {{XLEN{md_op.is_signed & src2[XLEN-1]}}, src2};
    assign product = mul_a * mul_b;

    assign mul_result = md_op.sel_hi ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    // operand magnitudes for the divider
    assign neg1 = md_op.is_signed & src1[XLEN-1];
    assign neg2 = md_op.is_signed & src2[XLEN-1];
    assign mag1 = neg1 ? -src1 : src1;
    assign mag2 = neg2 ? -src2 : src2;

    // one restoring step, next dividend bit comes from the quotient msb
    assign rem_shift = {rem, quo[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            div_done <= 1'b0;
        end else if (start) begin
            cnt      <= CNT_W'(XLEN);
            div_done <= 1'b0;
        end else if (cnt != '0) begin
            cnt      <= cnt - 1'b1;
            div_done <= (cnt == CNT_W'(1));
        end else begin
            div_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo     <= mag1;
            rem     <= '0;
            dvsr    <= mag2;
            quo_neg <= neg1 ^ neg2;
            rem_neg <= neg1;
            sel_rem <= md_op.sel_hi;
        end else if (cnt != '0) begin
            if (!rem_diff[XLEN]) begin
                rem <= rem_diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_shift[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix in the done cycle, held until the next start
    assign quo_fix = quo_neg ? -quo : quo;
    assign rem_fix = rem_neg ? -rem : rem;

    assign div_result = sel_rem ? rem_fix : quo_fix;

endmodule

// ==== exe_lsu_req.sv ====
`timescale 1ns/1ps

module exe_lsu_req
    import exe_pkg::*;
    import mem_pkg::*;
(
    input  mem_op_s   mem_op,
    input  logic      mem_active,
    input  logic      ms_allowin,
    input  word_t     addr,
    input  word_t     store_src,
    input  logic      data_sram_addr_ok,
    output logic      data_sram_req,
    output logic      data_sram_wr,
    output mem_size_t data_sram_size,
    output strb_t     data_sram_wstrb,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    output logic      ale,
    output logic      mem_ready
);

    logic  misalign;
    strb_t strb;
    word_t st_data;

    always_comb begin
        case (mem_op.size)
            SZ_HALF: misalign = addr[0];
            SZ_WORD: misalign = addr[1:0] != 2'b00;
            default: misalign = 1'b0;
        endcase
    end

    // lane replication and strobe by size
    always_comb begin
        case (mem_op.size)
            SZ_BYTE: begin
                st_data = {4{store_src[7:0]}};
                strb    = STRB_BYTE << addr[1:0];
            end
            SZ_HALF: begin
                st_data = {2{store_src[15:0]}};
                strb    = STRB_HALF << addr[1:0];
            end
            default: begin
                st_data = store_src;
                strb    = STRB_WORD;
            end
        endcase
    end

    assign ale = mem_active & misalign;

    // only ask when the result can move on in the same cycle
    assign data_sram_req   = mem_active & ~misalign & ms_allowin;
    assign data_sram_wr    = mem_op.is_store;
    assign data_sram_size  = mem_op.size;
    assign data_sram_wstrb = mem_op.is_store ? strb : '0;
    assign data_sram_addr  = addr;
    assign data_sram_wdata = st_data;

    assign mem_ready = ale | (data_sram_req & data_sram_addr_ok);

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage
    import exe_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid,
    output logic      es_allowin,
    input  op_class_t op_class,
    input  ex_op_t    op,
    input  logic      src1_is_pc,
    input  logic      src2_is_imm,
    input  logic      gr_we,
    input  logic [4:0] dest,
    input  word_t     pc,
    input  word_t     imm,
    input  word_t     rj_value,
    input  word_t     rkd_value,
    output logic      es_to_ms_valid,
    input  logic      ms_allowin,
    output word_t     es_result,
    output word_t     es_pc,
    output logic [4:0] es_dest,
    output logic      es_gr_we,
    output logic      es_ale,
    output logic      data_sram_req,
    output logic      data_sram_wr,
    output mem_size_t data_sram_size,
    output strb_t     data_sram_wstrb,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  logic      data_sram_addr_ok
);

    logic       es_valid;
    logic       es_ready_go;
    op_class_t  class_r;
    ex_op_t     op_r;
    logic       src1_is_pc_r;
    logic       src2_is_imm_r;
    logic       gr_we_r;
    logic [4:0] dest_r;
    word_t      pc_r;
    word_t      imm_r;
    word_t      rj_r;
    word_t      rkd_r;

    word_t      alu_src1;
    word_t      alu_src2;
    alu_fn_t    alu_fn;
    word_t      alu_result;
    word_t      mul_result;
    word_t      div_result;
    logic       is_div;
    logic       div_start;
    logic       div_done;
    logic       div_issued;
    logic       div_fin;
    logic       mem_active;
    logic       mem_ready;

    assign es_allowin     = ~es_valid | (es_ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid & es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            class_r       <= op_class;
            op_r          <= op;
            src1_is_pc_r  <= src1_is_pc;
            src2_is_imm_r <= src2_is_imm;
            gr_we_r       <= gr_we;
            dest_r        <= dest;
            pc_r          <= pc;
            imm_r         <= imm;
            rj_r          <= rj_value;
            rkd_r         <= rkd_value;
        end
    end

    assign alu_src1 = src1_is_pc_r ? pc_r : rj_r;
    assign alu_src2 = src2_is_imm_r ? imm_r : rkd_r;

    // memory ops reuse the adder for the address
    always_comb begin
        if (class_r == CLS_ALU) begin
            alu_fn = op_r.alu.fn;
        end else begin
            alu_fn = ALU_ADD;
        end
    end

    exe_alu u_alu (
        .alu_fn (alu_fn),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign is_div    = (class_r == CLS_MULDIV) & op_r.md.is_div;
    assign div_start = es_valid & is_div & ~div_issued;

    // start once per divide, remember done while the next stage stalls
    always_ff @(posedge clk) begin
        if (reset || es_allowin) begin
            div_issued <= 1'b0;
            div_fin    <= 1'b0;
        end else begin
            if (div_start) begin
                div_issued <= 1'b1;
            end
            if (div_done) begin
                div_fin <= 1'b1;
            end
        end
    end

    exe_muldiv u_muldiv (
        .clk        (clk),
        .reset      (reset),
        .md_op      (op_r.md),
        .src1       (alu_src1),
        .src2       (alu_src2),
        .start      (div_start),
        .mul_result (mul_result),
        .div_result (div_result),
        .div_done   (div_done)
    );

    assign mem_active = es_valid & (class_r == CLS_MEM);

    exe_lsu_req u_lsu_req (
        .mem_op            (op_r.mem),
        .mem_active        (mem_active),
        .ms_allowin        (ms_allowin),
        .addr              (alu_result),
        .store_src         (rkd_r),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .ale               (es_ale),
        .mem_ready         (mem_ready)
    );

    always_comb begin
        case (class_r)
            CLS_MULDIV: es_ready_go = ~is_div | div_done | div_fin;
            CLS_MEM:    es_ready_go = mem_ready;
            default:    es_ready_go = 1'b1;
        endcase
    end

    always_comb begin
        if (class_r == CLS_MULDIV) begin
            es_result = is_div ? div_result : mul_result;
        end else begin
            es_result = alu_result;
        end
    end

    assign es_pc    = pc_r;
    assign es_dest  = dest_r;
    assign es_gr_we = gr_we_r & ~es_ale;

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage
    import exe_pkg::*;
    import mem_pkg::*;
();

    localparam int N_INSTR        = 2000;
    localparam int TIMEOUT_CYCLES = N_INSTR * (XLEN + 2) + 1000;

    typedef struct packed {
        op_class_t   cls;
        logic        is_div;
        word_t       result;
        word_t       pc;
        logic [4:0]  dest;
        logic        gr_we;
        logic        ale;
        word_t       addr;
        word_t       wdata;
        strb_t       wstrb;
        mem_size_t   size;
        logic        wr;
        logic [31:0] acc_cycle;
    } exp_t;

    logic       clk;
    logic       reset;
    logic       ds_to_es_valid;
    logic       es_allowin;
    op_class_t  op_class;
    ex_op_t     op;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       gr_we;
    logic [4:0] dest;
    word_t      pc;
    word_t      imm;
    word_t      rj_value;
    word_t      rkd_value;
    logic       es_to_ms_valid;
    logic       ms_allowin;
    word_t      es_result;
    word_t      es_pc;
    logic [4:0] es_dest;
    logic       es_gr_we;
    logic       es_ale;
    logic       data_sram_req;
    logic       data_sram_wr;
    mem_size_t  data_sram_size;
    strb_t      data_sram_wstrb;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    logic       data_sram_addr_ok;

    logic [31:0] lfsr_state;
    int          cycle;
    int          sent;
    int          out_count;
    logic        taken;
    logic        valid_seen;
    logic        prev_stall;
    exp_t        offer;
    exp_t        held;
    exp_t        exp_q[$];

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    exe_stage uut (
        .clk               (clk),
        .reset             (reset),
        .ds_to_es_valid    (ds_to_es_valid),
        .es_allowin        (es_allowin),
        .op_class          (op_class),
        .op                (op),
        .src1_is_pc        (src1_is_pc),
        .src2_is_imm       (src2_is_imm),
        .gr_we             (gr_we),
        .dest              (dest),
        .pc                (pc),
        .imm               (imm),
        .rj_value          (rj_value),
        .rkd_value         (rkd_value),
        .es_to_ms_valid    (es_to_ms_valid),
        .ms_allowin        (ms_allowin),
        .es_result         (es_result),
        .es_pc             (es_pc),
        .es_dest           (es_dest),
        .es_gr_we          (es_gr_we),
        .es_ale            (es_ale),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // corner values show up often
    function automatic word_t pick_operand();
        logic [2:0] k;
        k = 3'(rand_bits(3));
        case (k)
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h8000_0000;
            3'd3:    return word_t'(rand_bits(4));
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic word_t alu_model(input alu_fn_t fn, input word_t a, input word_t b);
        case (fn)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic word_t mul_model(input logic sgn, input logic hi, input word_t a,
                                        input word_t b);
        longint      sa;
        longint      sb;
        logic [63:0] p;
        sa = $signed(a);
        sb = $signed(b);
        if (sgn) begin
            p = sa * sb;
        end else begin
            p = {32'b0, a} * {32'b0, b};
        end
        return hi ? p[63:32] : p[31:0];
    endfunction

    // divide the magnitudes and fix the signs after
    function automatic word_t div_model(input logic sgn, input logic rem_sel, input word_t a,
                                        input word_t b);
        logic  neg_a;
        logic  neg_b;
        word_t ma;
        word_t mb;
        word_t q;
        word_t r;
        neg_a = sgn & a[XLEN-1];
        neg_b = sgn & b[XLEN-1];
        ma = neg_a ? 32'd0 - a : a;
        mb = neg_b ? 32'd0 - b : b;
        if (mb == 0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (neg_a ^ neg_b) begin
            q = 32'd0 - q;
        end
        if (neg_a) begin
            r = 32'd0 - r;
        end
        return rem_sel ? r : q;
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_strb(input string name, input strb_t expected, input strb_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_size(input string name, input mem_size_t expected,
                              input mem_size_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic gen_instr();
        logic [2:0]  kind;
        logic [31:0] code;
        word_t       a;
        word_t       b;
        exp_t        e;
        kind = 3'(rand_bits(3));
        op = '0;
        src1_is_pc = 1'(rand_bits(1));
        src2_is_imm = 1'(rand_bits(1));
        gr_we = 1'(rand_bits(1));
        dest = 5'(rand_bits(5));
        pc = {30'(rand_bits(30)), 2'b00};
        imm = pick_operand();
        rj_value = pick_operand();
        rkd_value = pick_operand();
        e = '0;
        if (kind < 3'd4) begin
            op_class = CLS_ALU;
            code = rand_bits(4) % 12;
            op.alu.fn = alu_fn_t'(code[3:0]);
        end else if (kind < 3'd6) begin
            op_class = CLS_MULDIV;
            op.md.is_div = 1'(rand_bits(1));
            op.md.is_signed = 1'(rand_bits(1));
            op.md.sel_hi = 1'(rand_bits(1));
        end else begin
            // mostly aligned base plus offset
            op_class = CLS_MEM;
            src1_is_pc = 1'b0;
            src2_is_imm = 1'b1;
            if (rand_bits(2) != 0) begin
                rj_value[1:0] = 2'b00;
                imm[1:0] = 2'b00;
            end
            code = rand_bits(2) % 3;
            op.mem.size = mem_size_t'(code[1:0]);
            op.mem.is_store = 1'(rand_bits(1));
            op.mem.ld_unsigned = 1'(rand_bits(1));
        end
        a = src1_is_pc ? pc : rj_value;
        b = src2_is_imm ? imm : rkd_value;
        e.cls = op_class;
        e.pc = pc;
        e.dest = dest;
        e.gr_we = gr_we;
        case (op_class)
            CLS_ALU: e.result = alu_model(op.alu.fn, a, b);
            CLS_MULDIV: begin
                e.is_div = op.md.is_div;
                if (op.md.is_div) begin
                    e.result = div_model(op.md.is_signed, op.md.sel_hi, a, b);
                end else begin
                    e.result = mul_model(op.md.is_signed, op.md.sel_hi, a, b);
                end
            end
            default: begin
                e.addr = a + b;
                e.result = e.addr;
                e.size = op.mem.size;
                e.wr = op.mem.is_store;
                case (op.mem.size)
                    SZ_BYTE: begin
                        e.wdata = {4{rkd_value[7:0]}};
                        e.wstrb = 4'b0001 << e.addr[1:0];
                    end
                    SZ_HALF: begin
                        e.wdata = {2{rkd_value[15:0]}};
                        e.wstrb = 4'b0011 << e.addr[1:0];
                        e.ale = e.addr[0];
                    end
                    default: begin
                        e.wdata = rkd_value;
                        e.wstrb = 4'b1111;
                        e.ale = e.addr[1:0] != 2'b00;
                    end
                endcase
                if (!op.mem.is_store) begin
                    e.wstrb = '0;
                end
                e.gr_we = gr_we & ~e.ale;
            end
        endcase
        offer = e;
    endtask

    task automatic drive();
        if (!ds_to_es_valid || taken) begin
            if (sent < N_INSTR && rand_bits(2) != 0) begin
                gen_instr();
                ds_to_es_valid = 1'b1;
            end else begin
                ds_to_es_valid = 1'b0;
            end
        end
        ms_allowin = rand_bits(2) != 0;
        data_sram_addr_ok = 1'(rand_bits(1));
    endtask

    // sampled mid-cycle where values hold until the next rising edge
    task automatic observe();
        exp_t head;
        exp_t e;
        if (prev_stall) begin
            check_bit("stall valid", 1'b1, es_to_ms_valid);
            check_word("stall result", held.result, es_result);
            check_word("stall pc", held.pc, es_pc);
            check_word("stall dest", word_t'(held.dest), word_t'(es_dest));
            check_bit("stall gr_we", held.gr_we, es_gr_we);
            check_bit("stall ale", held.ale, es_ale);
        end
        if (data_sram_req) begin
            if (exp_q.size() == 0) begin
                fail_stop("data_sram_req raised while the stage was empty");
            end else begin
                head = exp_q[0];
                if (head.cls != CLS_MEM || head.ale) begin
                    fail_stop("data_sram_req raised for a misaligned or non-memory access");
                end else if (data_sram_addr_ok) begin
                    check_word("sram addr", head.addr, data_sram_addr);
                    check_word("sram wdata", head.wdata, data_sram_wdata);
                    check_strb("sram wstrb", head.wstrb, data_sram_wstrb);
                    check_size("sram size", head.size, data_sram_size);
                    check_bit("sram wr", head.wr, data_sram_wr);
                    check_bit("sram accept valid", 1'b1, es_to_ms_valid);
                end
            end
        end
        if (es_to_ms_valid) begin
            if (exp_q.size() == 0) begin
                fail_stop("es_to_ms_valid raised with no instruction in the stage");
            end else begin
                head = exp_q[0];
                if (!valid_seen && (head.cls != CLS_MEM || head.ale)) begin
                    check_word(head.is_div ? "divide latency" : "single-cycle latency",
                               head.is_div ? word_t'(XLEN + 2) : word_t'(1),
                               word_t'(cycle - head.acc_cycle));
                end
                if (head.cls == CLS_MEM && !head.ale) begin
                    check_bit("sram accepted with result", 1'b1,
                              data_sram_req & data_sram_addr_ok);
                end
                valid_seen = 1'b1;
                if (ms_allowin) begin
                    head = exp_q.pop_front();
                    check_word("result", head.result, es_result);
                    check_word("pc", head.pc, es_pc);
                    check_word("dest", word_t'(head.dest), word_t'(es_dest));
                    check_bit("gr_we", head.gr_we, es_gr_we);
                    check_bit("ale", head.ale, es_ale);
                    out_count++;
                    valid_seen = 1'b0;
                end
            end
        end
        taken = ds_to_es_valid && es_allowin;
        if (taken) begin
            e = offer;
            e.acc_cycle = cycle;
            exp_q.push_back(e);
            sent++;
        end
        prev_stall = es_to_ms_valid && !ms_allowin;
        held.result = es_result;
        held.pc = es_pc;
        held.dest = es_dest;
        held.gr_we = es_gr_we;
        held.ale = es_ale;
    endtask

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
            if (cycle >= TIMEOUT_CYCLES) begin
                fail_stop("simulation timed out waiting for results");
            end
        end
    end

    initial begin
        lfsr_state = 32'h13b8;
        ds_to_es_valid = 1'b0;
        op_class = CLS_ALU;
        op = '0;
        src1_is_pc = 1'b0;
        src2_is_imm = 1'b0;
        gr_we = 1'b0;
        dest = '0;
        pc = '0;
        imm = '0;
        rj_value = '0;
        rkd_value = '0;
        ms_allowin = 1'b0;
        data_sram_addr_ok = 1'b0;
        sent = 0;
        out_count = 0;
        taken = 1'b0;
        valid_seen = 1'b0;
        prev_stall = 1'b0;
        offer = '0;
        held = '0;
        @(negedge reset);
        while (out_count < N_INSTR) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            #1;
            drive();
        end
        // idle cycles where a repeated result or request shows up
        repeat (4) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            #1;
            drive();
        end
        @(negedge clk);
        if (!es_allowin) begin
            fail_stop("stage still occupied after the last result");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
mem_pkg.sv
exe_pkg.sv
exe_alu.sv
exe_muldiv.sv
exe_lsu_req.sv
exe_stage.sv
tb_clock.sv
tb_exe_stage.sv
